/* Makefile */
TOP = tb_pcie_inbound_write

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* src/axi_write_issue.sv */
module axi_write_issue
    import pcie_tlp_pkg::*, axi_write_pkg::*;
(
    input  logic                  axi_clk,
    input  logic                  reset,
    input  axi_aw_t               aw_in,
    input  logic                  aw_start,
    output logic                  aw_done,
    output logic                  aw_valid,
    input  logic                  aw_ready,
    output axi_aw_t               aw,
    input  logic                  data_phase,
    input  logic                  rx_valid,
    input  logic [TLP_DATA_W-1:0] rx_data,
    output logic                  rx_ready_data,
    input  logic [BE_W-1:0]       first_be,
    input  logic [BE_W-1:0]       last_be,
    input  logic                  first_beat,
    input  logic                  last_beat,
    output logic                  w_valid,
    input  logic                  w_ready,
    output axi_w_t                w,
    output logic                  w_fire,
    input  logic                  b_valid,
    input  axi_resp_e             b_resp,
    output logic                  b_ready,
    input  logic                  outstanding_nz,
    output logic                  b_fire,
    output logic                  b_err
);

    always_ff @(posedge axi_clk) begin
        if (aw_start) begin
            aw <= aw_in;
        end
    end

    always_ff @(posedge axi_clk) begin
        if (reset) begin
            aw_valid <= 1'b0;
        end else if (aw_start) begin
            aw_valid <= 1'b1;
        end else if (aw_ready) begin
            aw_valid <= 1'b0;
        end
    end

    assign aw_done = aw_valid && aw_ready;

    // Payload passes straight from the receive stream
    assign w_valid       = data_phase && rx_valid;
    assign rx_ready_data = data_phase && w_ready;
    assign w_fire        = w_valid && w_ready;

    always_comb begin
        w.data = rx_data;
        w.last = last_beat;
        if (first_beat) begin
            w.strb = first_be;
        end else if (last_beat) begin
            w.strb = last_be;
        end else begin
            w.strb = '1;
        end
    end

    assign b_ready = outstanding_nz;
    assign b_fire  = b_valid && b_ready;

    always_ff @(posedge axi_clk) begin
        if (reset) begin
            b_err <= 1'b0;
        end else begin
            b_err <= b_fire && (b_resp != okay);
        end
    end

endmodule

/* src/axi_write_pkg.sv */
package axi_write_pkg;

    localparam int AXI_ADDR_W = 32;
    localparam int AXI_LEN_W  = 4;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    // Write response codes
    typedef enum logic [1:0] {
        okay   = 2'b00,
        exokay = 2'b01,
        slverr = 2'b10,
        decerr = 2'b11
    } axi_resp_e;

    // Write address channel payload
    typedef struct packed {
        logic [AXI_ADDR_W-1:0]  addr;
        logic [AXI_LEN_W-1:0]   len;
    } axi_aw_t;

    // Write data channel payload
    typedef struct packed {
        logic [AXI_DATA_W-1:0]  data;
        logic [AXI_STRB_W-1:0]  strb;
        logic                   last;
    } axi_w_t;

endpackage

/* src/bar_translate.sv */
module bar_translate
    import pcie_tlp_pkg::*, axi_write_pkg::*;
#(
    parameter bar_table_t BAR_MASK = '1,
    parameter bar_table_t BAR_BASE = '0
) (
    input  logic     axi_clk,
    input  logic     reset,
    input  tlp_hdr_t hdr,
    input  logic     hdr_valid,
    output axi_aw_t  aw
);

    localparam int BAR_IDX_W = $clog2(NUM_BARS);

    logic [BAR_IDX_W-1:0]  bar_sel;
    logic [AXI_ADDR_W-1:0] byte_addr;
    logic [AXI_ADDR_W-1:0] mask;
    logic [AXI_ADDR_W-1:0] xlat_addr;

    // Lowest BAR that was hit wins
    always_comb begin
        bar_sel = '0;
        for (int i = NUM_BARS - 1; i >= 0; i--) begin
            if (hdr.bar[i]) begin
                bar_sel = BAR_IDX_W'(i);
            end
        end
    end

    assign byte_addr = {hdr.addr, 2'b00};
    assign mask      = BAR_MASK[bar_sel];
    assign xlat_addr = (byte_addr & mask) | (BAR_BASE[bar_sel] & ~mask);

    always_ff @(posedge axi_clk) begin
        if (reset) begin
            aw <= '0;
        end else if (hdr_valid) begin
            aw.addr <= xlat_addr;
            aw.len  <= AXI_LEN_W'(hdr.length - 1'b1);
        end
    end

endmodule

/* src/pcie_inbound_write.sv */
module pcie_inbound_write
    import pcie_tlp_pkg::*, axi_write_pkg::*;
#(
    parameter int         MOT      = 4,
    parameter bar_table_t BAR_MASK = '1,
    parameter bar_table_t BAR_BASE = '0
) (
    input  logic         axi_clk,
    input  logic         reset,

    // TLP receive stream
    input  logic         rx_valid,
    output logic         rx_ready,
    input  tlp_rx_beat_t rx_beat,

    // AXI write channels
    output logic         aw_valid,
    input  logic         aw_ready,
    output axi_aw_t      aw,
    output logic         w_valid,
    input  logic         w_ready,
    output axi_w_t       w,
    input  logic         b_valid,
    output logic         b_ready,
    input  axi_resp_e    b_resp,

    // Error report and status
    output logic         err_valid,
    output logic         err_unsupported,
    output logic         busy
);

    tlp_hdr_t hdr;
    logic     hdr_valid;
    axi_aw_t  aw_xlat;
    logic     rx_ready_hdr;
    logic     rx_ready_data;
    logic     aw_start;
    logic     aw_done;
    logic     data_phase;
    logic     first_beat;
    logic     last_beat;
    logic     at_limit;
    logic     w_fire;
    logic     b_fire;
    logic     b_err;
    logic     outstanding_nz;
    logic [$clog2(MOT+1)-1:0] outstanding;

    assign rx_ready = rx_ready_hdr | rx_ready_data;

    tlp_rx_fsm tlp_rx_fsm_inst (
        .axi_clk         ( axi_clk ),
        .reset           ( reset ),
        .rx_valid        ( rx_valid ),
        .rx_beat         ( rx_beat ),
        .rx_ready_hdr    ( rx_ready_hdr ),
        .hdr             ( hdr ),
        .hdr_valid       ( hdr_valid ),
        .aw_start        ( aw_start ),
        .aw_done         ( aw_done ),
        .at_limit        ( at_limit ),
        .data_phase      ( data_phase ),
        .w_fire          ( w_fire ),
        .last_beat       ( last_beat ),
        .b_err           ( b_err ),
        .outstanding_nz  ( outstanding_nz ),
        .err_valid       ( err_valid ),
        .err_unsupported ( err_unsupported ),
        .busy            ( busy )
    );

    bar_translate #(
        .BAR_MASK ( BAR_MASK ),
        .BAR_BASE ( BAR_BASE )
    ) bar_translate_inst (
        .axi_clk   ( axi_clk ),
        .reset     ( reset ),
        .hdr       ( hdr ),
        .hdr_valid ( hdr_valid ),
        .aw        ( aw_xlat )
    );

    write_tracker #(
        .MOT ( MOT )
    ) write_tracker_inst (
        .axi_clk        ( axi_clk ),
        .reset          ( reset ),
        .hdr_valid      ( hdr_valid ),
        .length         ( hdr.length ),
        .w_fire         ( w_fire ),
        .aw_fire        ( aw_done ),
        .b_fire         ( b_fire ),
        .first_beat     ( first_beat ),
        .last_beat      ( last_beat ),
        .at_limit       ( at_limit ),
        .outstanding    ( outstanding ),
        .outstanding_nz ( outstanding_nz )
    );

    axi_write_issue axi_write_issue_inst (
        .axi_clk        ( axi_clk ),
        .reset          ( reset ),
        .aw_in          ( aw_xlat ),
        .aw_start       ( aw_start ),
        .aw_done        ( aw_done ),
        .aw_valid       ( aw_valid ),
        .aw_ready       ( aw_ready ),
        .aw             ( aw ),
        .data_phase     ( data_phase ),
        .rx_valid       ( rx_valid ),
        .rx_data        ( rx_beat.data ),
        .rx_ready_data  ( rx_ready_data ),
        .first_be       ( hdr.first_be ),
        .last_be        ( hdr.last_be ),
        .first_beat     ( first_beat ),
        .last_beat      ( last_beat ),
        .w_valid        ( w_valid ),
        .w_ready        ( w_ready ),
        .w              ( w ),
        .w_fire         ( w_fire ),
        .b_valid        ( b_valid ),
        .b_resp         ( b_resp ),
        .b_ready        ( b_ready ),
        .outstanding_nz ( outstanding_nz ),
        .b_fire         ( b_fire ),
        .b_err          ( b_err )
    );

endmodule

/* src/pcie_tlp_pkg.sv */
package pcie_tlp_pkg;

    localparam int TLP_DATA_W   = 32;
    localparam int TLP_LEN_W    = 10;
    localparam int BE_W         = 4;
    localparam int NUM_BARS     = 7;

    // Dword address carried in the header, bits [31:2] of the byte address
    localparam int TLP_DWADDR_W = axi_write_pkg::AXI_ADDR_W - 2;

    // Request opcodes after classification
    typedef enum logic [1:0] {
        mem_wr32    = 2'd0,
        mem_wr64    = 2'd1,
        unsupported = 2'd2
    } tlp_kind_e;

    // One dword on the receive stream
    typedef struct packed {
        logic [TLP_DATA_W-1:0]  data;
        logic                   last;
        logic [NUM_BARS-1:0]    bar;
    } tlp_rx_beat_t;

    // Decoded request header
    typedef struct packed {
        tlp_kind_e              kind;
        logic [TLP_LEN_W-1:0]   length;
        logic [BE_W-1:0]        first_be;
        logic [BE_W-1:0]        last_be;
        logic [TLP_DWADDR_W-1:0] addr;
        logic [NUM_BARS-1:0]    bar;
    } tlp_hdr_t;

    // Per BAR translation values, index 6 is the expansion ROM
    typedef logic [NUM_BARS-1:0][axi_write_pkg::AXI_ADDR_W-1:0] bar_table_t;

endpackage

/* src/tlp_rx_fsm.sv */
module tlp_rx_fsm
    import pcie_tlp_pkg::*, axi_write_pkg::*;
(
    input  logic         axi_clk,
    input  logic         reset,
    input  logic         rx_valid,
    input  tlp_rx_beat_t rx_beat,
    output logic         rx_ready_hdr,
    output tlp_hdr_t     hdr,
    output logic         hdr_valid,
    output logic         aw_start,
    input  logic         aw_done,
    input  logic         at_limit,
    output logic         data_phase,
    input  logic         w_fire,
    input  logic         last_beat,
    input  logic         b_err,
    input  logic         outstanding_nz,
    output logic         err_valid,
    output logic         err_unsupported,
    output logic         busy
);

    localparam int MAX_LEN = 2 ** AXI_LEN_W;
    localparam int ERR_W   = 4;

    typedef enum logic [2:0] {
        hdr0, hdr1, hdr2, hdr3, translate, issue_aw, data, drain
    } state_e;

    state_e               state;
    logic                 rx_fire;
    logic                 aw_started;
    logic                 unsup_q;
    logic [ERR_W-1:0]     err_pend;
    logic [1:0]           fmt;
    logic [4:0]           tlp_type;
    logic [TLP_LEN_W-1:0] len;
    tlp_kind_e            kind_dec;

    assign rx_ready_hdr = state inside {hdr0, hdr1, hdr2, hdr3, drain};
    assign rx_fire      = rx_valid && rx_ready_hdr;
    assign aw_start     = (state == issue_aw) && !aw_started && !at_limit;
    assign data_phase   = (state == data);
    assign busy         = (state != hdr0) || outstanding_nz;

    // Classify from the first header dword
    always_comb begin
        fmt      = rx_beat.data[30:29];
        tlp_type = rx_beat.data[28:24];
        len      = rx_beat.data[TLP_LEN_W-1:0];
        if (fmt[1] && tlp_type == 5'd0 && len != '0 && len <= TLP_LEN_W'(MAX_LEN)) begin
            kind_dec = fmt[0] ? mem_wr64 : mem_wr32;
        end else begin
            kind_dec = unsupported;
        end
    end

    // Header fields
    always_ff @(posedge axi_clk) begin
        if (rx_fire) begin
            case (state)
                hdr0: begin
                    hdr.kind   <= kind_dec;
                    hdr.length <= len;
                    hdr.bar    <= rx_beat.bar;
                end
                hdr1: begin
                    hdr.last_be  <= rx_beat.data[7:4];
                    hdr.first_be <= rx_beat.data[3:0];
                end
                // For 4DW the upper dword lands here and is overwritten in hdr3
                hdr2, hdr3: hdr.addr <= rx_beat.data[31:2];
                default: ;
            endcase
        end
    end

    always_ff @(posedge axi_clk) begin
        if (reset) begin
            state      <= hdr0;
            hdr_valid  <= 1'b0;
            aw_started <= 1'b0;
            unsup_q    <= 1'b0;
        end else begin
            hdr_valid <= 1'b0;
            unsup_q   <= 1'b0;
            case (state)
                hdr0, hdr1, hdr2, hdr3: begin
                    if (rx_fire) begin
                        if (rx_beat.last) begin
                            // TLP ended inside the header
                            unsup_q <= 1'b1;
                            state   <= hdr0;
                        end else if (state == hdr0) begin
                            state <= hdr1;
                        end else if (state == hdr1) begin
                            state <= hdr2;
                        end else if (state == hdr2 &&
                                     (hdr.kind == unsupported || hdr.bar == '0)) begin
                            state <= drain;
                        end else if (state == hdr2 && hdr.kind == mem_wr64) begin
                            state <= hdr3;
                        end else begin
                            hdr_valid <= 1'b1;
                            state     <= translate;
                        end
                    end
                end
                translate: state <= issue_aw;
                issue_aw: begin
                    if (aw_start) begin
                        aw_started <= 1'b1;
                    end
                    if (aw_done) begin
                        aw_started <= 1'b0;
                        state      <= data;
                    end
                end
                data: begin
                    if (w_fire && last_beat) begin
                        state <= hdr0;
                    end
                end
                drain: begin
                    if (rx_fire && rx_beat.last) begin
                        unsup_q <= 1'b1;
                        state   <= hdr0;
                    end
                end
                default: state <= hdr0;
            endcase
        end
    end

    // AXI errors that collide with an unsupported report wait their turn
    always_ff @(posedge axi_clk) begin
        if (reset) begin
            err_pend <= '0;
        end else begin
            err_pend <= err_pend
                      + ERR_W'(b_err && (unsup_q || err_pend != '0))
                      - ERR_W'(!unsup_q && err_pend != '0);
        end
    end

    assign err_valid       = unsup_q || err_pend != '0 || b_err;
    assign err_unsupported = unsup_q;

endmodule

/* src/write_tracker.sv */
module write_tracker
    import pcie_tlp_pkg::*, axi_write_pkg::*;
#(
    parameter int MOT = 4
) (
    input  logic                     axi_clk,
    input  logic                     reset,
    input  logic                     hdr_valid,
    input  logic [TLP_LEN_W-1:0]     length,
    input  logic                     w_fire,
    input  logic                     aw_fire,
    input  logic                     b_fire,
    output logic                     first_beat,
    output logic                     last_beat,
    output logic                     at_limit,
    output logic [$clog2(MOT+1)-1:0] outstanding,
    output logic                     outstanding_nz
);

    localparam int CNT_W = $clog2(MOT + 1);

    // Holds 1 to 16 dwords
    logic [AXI_LEN_W:0] remaining;

    always_ff @(posedge axi_clk) begin
        if (reset) begin
            remaining  <= '0;
            first_beat <= 1'b0;
        end else if (hdr_valid) begin
            remaining  <= length[AXI_LEN_W:0];
            first_beat <= 1'b1;
        end else if (w_fire) begin
            remaining  <= remaining - 1'b1;
            first_beat <= 1'b0;
        end
    end

    assign last_beat = (remaining == (AXI_LEN_W+1)'(1));

    // Writes between AW handshake and B acceptance
    always_ff @(posedge axi_clk) begin
        if (reset) begin
            outstanding <= '0;
        end else begin
            case ({aw_fire, b_fire})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    assign at_limit       = (outstanding == CNT_W'(MOT));
    assign outstanding_nz = (outstanding != '0);

endmodule

/* tb.f */
src/axi_write_pkg.sv
src/pcie_tlp_pkg.sv
src/bar_translate.sv
src/write_tracker.sv
src/axi_write_issue.sv
src/tlp_rx_fsm.sv
src/pcie_inbound_write.sv
test/tb_clock_gen.sv
test/pcie_inbound_write_assertions.sv
test/tb_pcie_inbound_write.sv

/* test/pcie_inbound_write_assertions.sv */
module pcie_inbound_write_assertions
    import axi_write_pkg::*;
#(
    parameter int MOT = 4
) (
    input  logic                     axi_clk,
    input  logic                     reset,
    input  logic                     aw_valid,
    input  logic                     aw_ready,
    input  axi_aw_t                  aw,
    input  logic                     w_valid,
    input  logic                     w_ready,
    input  axi_w_t                   w,
    input  logic [$clog2(MOT+1)-1:0] outstanding
);

    timeunit 1ns;
    timeprecision 100ps;

    // AW held with stable content until accepted
    aw_stable_until_ready: assert property (@(posedge axi_clk) disable iff (reset)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else $error("aw_valid dropped or aw changed before aw_ready");

    // Same rule on the W channel
    w_stable_until_ready: assert property (@(posedge axi_clk) disable iff (reset)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else $error("w_valid dropped or w changed before w_ready");

    outstanding_in_range: assert property (@(posedge axi_clk) disable iff (reset)
        outstanding <= ($clog2(MOT+1))'(MOT))
        else $error("outstanding write count above limit");

endmodule

/* test/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic axi_clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        axi_clk = 1'b0;
        forever #(PERIOD_NS / 2) axi_clk = ~axi_clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge axi_clk);
        reset <= 1'b0;
    end

endmodule

/* test/tb_pcie_inbound_write.sv */
module tb_pcie_inbound_write
    import pcie_tlp_pkg::*, axi_write_pkg::*;
;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MOT         = 4;
    localparam int NUM_ENTRIES = 11;
    localparam int HOLD_CYCLES = 30;

    // Index 0 is the rightmost word
    localparam bar_table_t BAR_MASK = {
        {4{32'hFFFF_FFFF}}, 32'h000F_FFFF, 32'h0000_FFFF, 32'h0000_0FFF
    };
    localparam bar_table_t BAR_BASE = {
        {4{32'h0000_0000}}, 32'h3000_0000, 32'h2000_0000, 32'h1000_0000
    };

    typedef struct packed {
        logic [7:0]           fmt_type;
        logic [TLP_LEN_W-1:0] length;
        logic [NUM_BARS-1:0]  bar;
        logic [31:0]          addr_hi;
        logic [31:0]          addr;
        logic [3:0]           first_be;
        logic [3:0]           last_be;
        axi_resp_e            resp;
        logic                 unsup;
    } tlp_entry_t;

    logic         axi_clk;
    logic         reset;
    logic         rx_valid;
    logic         rx_ready;
    tlp_rx_beat_t rx_beat;
    logic         aw_valid;
    logic         aw_ready;
    axi_aw_t      aw;
    logic         w_valid;
    logic         w_ready;
    axi_w_t       w;
    logic         b_valid;
    logic         b_ready;
    axi_resp_e    b_resp;
    logic         err_valid;
    logic         err_unsupported;
    logic         busy;

    tlp_entry_t   tests [NUM_ENTRIES];
    axi_aw_t      aw_exp [$];
    axi_resp_e    resp_exp [$];
    axi_w_t       w_exp [$];
    axi_resp_e    b_pending [$];
    logic [15:0]  payload_lfsr;
    logic [15:0]  slave_lfsr;
    logic         hold_b;
    int           aw_count;
    int           b_count;
    int           unsup_errs;
    int           axi_errs;
    int           exp_unsup;
    int           exp_axi;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(4)) clock_gen (
        .axi_clk ( axi_clk ),
        .reset   ( reset )
    );

    pcie_inbound_write #(
        .MOT      ( MOT ),
        .BAR_MASK ( BAR_MASK ),
        .BAR_BASE ( BAR_BASE )
    ) DUT (.*);

    bind pcie_inbound_write pcie_inbound_write_assertions #(.MOT(MOT)) protocol_checks (.*);

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_with_failure("value mismatch");
        end
    endtask

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [31:0] draw_bits(inout logic [15:0] state, input int n);
        logic        fb;
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb    = state[15] ^ state[13] ^ state[12] ^ state[10];
            state = {state[14:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic logic [31:0] expected_addr(input tlp_entry_t e);
        int          sel;
        logic [31:0] byte_addr;
        sel = 0;
        for (int i = NUM_BARS - 1; i >= 0; i--) begin
            if (e.bar[i]) begin
                sel = i;
            end
        end
        byte_addr = {e.addr[31:2], 2'b00};
        return (byte_addr & BAR_MASK[sel]) | (BAR_BASE[sel] & ~BAR_MASK[sel]);
    endfunction

    task automatic send_dword(input logic [31:0] data, input logic last,
                              input logic [NUM_BARS-1:0] bar);
        rx_valid <= 1'b1;
        rx_beat  <= '{data: data, last: last, bar: bar};
        @(negedge axi_clk);
        while (!rx_ready) @(negedge axi_clk);
        @(posedge axi_clk);
    endtask

    task automatic send_tlp(input tlp_entry_t e);
        logic [31:0] hdr_dw [4];
        int          n_hdr;
        int          n_pay;
        logic [31:0] data;
        axi_w_t      beat;
        n_hdr     = e.fmt_type[5] ? 4 : 3;
        n_pay     = e.fmt_type[6] ? int'(e.length) : 0;
        hdr_dw[0] = {e.fmt_type, 14'd0, e.length};
        hdr_dw[1] = {24'd0, e.last_be, e.first_be};
        hdr_dw[2] = (n_hdr == 4) ? e.addr_hi : e.addr;
        hdr_dw[3] = e.addr;
        if (!e.unsup) begin
            aw_exp.push_back('{addr: expected_addr(e), len: 4'(e.length - 1)});
            resp_exp.push_back(e.resp);
        end
        for (int i = 0; i < n_hdr; i++) begin
            send_dword(hdr_dw[i], n_pay == 0 && i == n_hdr - 1, e.bar);
        end
        for (int i = 0; i < n_pay; i++) begin
            data = draw_bits(payload_lfsr, 32);
            if (!e.unsup) begin
                beat.data = data;
                beat.last = (i == n_pay - 1);
                if (i == 0) begin
                    beat.strb = e.first_be;
                end else if (i == n_pay - 1) begin
                    beat.strb = e.last_be;
                end else begin
                    beat.strb = 4'hF;
                end
                w_exp.push_back(beat);
            end
            send_dword(data, i == n_pay - 1, e.bar);
        end
    endtask

    // Channel monitors sampled mid cycle
    always @(negedge axi_clk) begin
        if (!reset) begin
            if (aw_valid && aw_ready) begin
                if (aw_exp.size() == 0) begin
                    stop_with_failure("AW handshake with no write expected");
                end
                check_value("aw.addr", aw.addr, aw_exp[0].addr);
                check_value("aw.len", aw.len, aw_exp[0].len);
                void'(aw_exp.pop_front());
                b_pending.push_back(resp_exp.pop_front());
                aw_count++;
            end
            if (w_valid && w_ready) begin
                if (w_exp.size() == 0) begin
                    stop_with_failure("W handshake with no beat expected");
                end
                check_value("w.data", w.data, w_exp[0].data);
                check_value("w.strb", w.strb, w_exp[0].strb);
                check_value("w.last", w.last, w_exp[0].last);
                void'(w_exp.pop_front());
            end
            if (b_valid && b_ready) begin
                b_count++;
            end
            if (aw_count - b_count > MOT) begin
                stop_with_failure("more writes in flight than the limit allows");
            end
            // A write still waits for its B response
            if (aw_count > b_count) begin
                check_value("busy", busy, 1'b1);
            end
            if (err_valid && err_unsupported) begin
                unsup_errs++;
            end else if (err_valid) begin
                axi_errs++;
            end
        end
    end

    // AXI slave ready lines high about three cycles in four
    initial begin
        logic [31:0] bits;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        forever begin
            @(posedge axi_clk);
            bits = draw_bits(slave_lfsr, 2);
            aw_ready <= |bits[1:0];
            bits = draw_bits(slave_lfsr, 2);
            w_ready <= |bits[1:0];
        end
    end

    // B responses in order after a random delay
    initial begin
        logic [31:0] delay;
        b_valid = 1'b0;
        b_resp  = okay;
        forever begin
            @(negedge axi_clk);
            if (!hold_b && b_pending.size() > 0) begin
                delay = draw_bits(slave_lfsr, 3);
                repeat (delay) @(posedge axi_clk);
                @(posedge axi_clk);
                b_valid <= 1'b1;
                b_resp  <= b_pending.pop_front();
                @(negedge axi_clk);
                while (!b_ready) @(negedge axi_clk);
                @(posedge axi_clk);
                b_valid <= 1'b0;
            end
        end
    end

    // First MOT writes get no B until the limit has been observed
    initial begin
        @(negedge axi_clk);
        while (aw_count < MOT) @(negedge axi_clk);
        @(negedge axi_clk);
        // Next write header taken and its AW held back
        while (!(rx_valid && !rx_ready && !w_valid)) @(negedge axi_clk);
        repeat (HOLD_CYCLES) @(negedge axi_clk);
        check_value("aw_count", aw_count, MOT);
        check_value("busy", busy, 1'b1);
        hold_b = 1'b0;
    end

    initial begin
        repeat (NUM_ENTRIES * 200) @(posedge axi_clk);
        stop_with_failure("timeout: the DUT did not finish the test sequence");
    end

    initial begin
        rx_valid     = 1'b0;
        rx_beat      = '0;
        hold_b       = 1'b1;
        payload_lfsr = 16'd63;
        slave_lfsr   = 16'd63;
        aw_count     = 0;
        b_count      = 0;
        unsup_errs   = 0;
        axi_errs     = 0;
        exp_unsup    = 0;
        exp_axi      = 0;

        tests[0]  = '{8'h40, 10'd1,  7'h01, 32'h0, 32'h0000_0A54, 4'h3, 4'h0, okay,   1'b0};
        tests[1]  = '{8'h40, 10'd4,  7'h02, 32'h0, 32'hDEAD_1230, 4'hF, 4'h1, okay,   1'b0};
        tests[2]  = '{8'h60, 10'd2,  7'h04, 32'hFFFF_FFFF, 32'h0012_3450, 4'hE, 4'h7,
                      okay, 1'b0};
        tests[3]  = '{8'h40, 10'd16, 7'h08, 32'h0, 32'h8000_0000, 4'hF, 4'hF, okay,   1'b0};
        tests[4]  = '{8'h40, 10'd3,  7'h06, 32'h0, 32'h0000_4444, 4'h1, 4'h8, okay,   1'b0};
        // Memory read, oversize length, no BAR hit
        tests[5]  = '{8'h00, 10'd1,  7'h01, 32'h0, 32'h0000_0100, 4'hF, 4'h0, okay,   1'b1};
        tests[6]  = '{8'h40, 10'd17, 7'h01, 32'h0, 32'h0000_0200, 4'hF, 4'hF, okay,   1'b1};
        tests[7]  = '{8'h40, 10'd2,  7'h00, 32'h0, 32'h0000_0300, 4'hF, 4'hF, okay,   1'b1};
        tests[8]  = '{8'h40, 10'd5,  7'h01, 32'h0, 32'h0000_0F00, 4'hC, 4'h3, slverr, 1'b0};
        tests[9]  = '{8'h60, 10'd1,  7'h40, 32'h1234_5678, 32'hCAFE_0008, 4'h8, 4'h0,
                      decerr, 1'b0};
        tests[10] = '{8'h40, 10'd8,  7'h10, 32'h0, 32'h5555_AAA8, 4'hF, 4'hF, okay,   1'b0};

        @(negedge axi_clk);
        while (reset) @(negedge axi_clk);
        check_value("rx_ready", rx_ready, 1'b1);
        check_value("busy", busy, 1'b0);
        check_value("aw_valid", aw_valid, 1'b0);
        check_value("w_valid", w_valid, 1'b0);
        check_value("err_valid", err_valid, 1'b0);
        @(posedge axi_clk);

        for (int t = 0; t < NUM_ENTRIES; t++) begin
            if (tests[t].unsup) begin
                exp_unsup++;
            end else if (tests[t].resp != okay) begin
                exp_axi++;
            end
            send_tlp(tests[t]);
        end
        rx_valid <= 1'b0;

        @(negedge axi_clk);
        while (busy || b_pending.size() != 0) @(negedge axi_clk);
        // Error strobe trails the last B by a cycle
        repeat (3) @(negedge axi_clk);
        check_value("unsupported error count", unsup_errs, exp_unsup);
        check_value("axi error count", axi_errs, exp_axi);
        if (aw_exp.size() != 0 || w_exp.size() != 0) begin
            stop_with_failure("expected AW or W transfers never happened");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule
